// ==== rtl/lcdPkg.sv ====
`default_nettype none

package lcdPkg;

	// One byte on the LCD data bus, command or character code
	typedef logic [7:0] lcdByte_t;

	// Status selector code
	typedef logic [2:0] msgSel_t;

	// Position within a message table
	typedef logic [5:0] tableIndex_t;

	// Register-select on top of the bus byte
	typedef logic [8:0] romWord_t;

	// Table layout: init commands, line one, line change, line two
	localparam int lineOneBase = 5;
	localparam int lineChangeIndex = lineOneBase + 16;
	localparam int lineTwoBase = lineChangeIndex + 1;
	localparam int tableLength = lineTwoBase + 16;

endpackage

`default_nettype wire

// ==== rtl/lcdMessageRom.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdMessageRom (
	input  lcdPkg::msgSel_t     msg,
	input  lcdPkg::tableIndex_t index,
	output lcdPkg::romWord_t    word
);

	// Selector codes with their own text
	localparam lcdPkg::msgSel_t msgBanner = 3'd0;
	localparam lcdPkg::msgSel_t msgInit = 3'd1;
	localparam lcdPkg::msgSel_t msgConfig = 3'd2;
	localparam lcdPkg::msgSel_t msgRunning = 3'd3;
	localparam lcdPkg::msgSel_t msgConnecting = 3'd7;

	// HD44780 commands, register-select low
	// Function set is 8-bit bus, two lines, 5x8 font
	localparam lcdPkg::romWord_t cmdFunctionSet = 9'h038;
	localparam lcdPkg::romWord_t cmdDisplayOn = 9'h00C;
	localparam lcdPkg::romWord_t cmdClear = 9'h001;
	localparam lcdPkg::romWord_t cmdEntryMode = 9'h006;
	localparam lcdPkg::romWord_t cmdHome = 9'h080;
	localparam lcdPkg::romWord_t cmdLineTwo = 9'h0C0;
	localparam lcdPkg::romWord_t blankChar = 9'h120;

	// Texts padded with spaces to the full 16 columns
	localparam logic [127:0] textBanner = "Banc-d-Test SAFE";
	localparam logic [127:0] textInit = "STATE: INIT     ";
	localparam logic [127:0] textConfig = "STATE: CONFIG   ";
	localparam logic [127:0] textRunning = "STATE: RUNNING  ";
	localparam logic [127:0] textConnecting = "STATE: CONNECTIN";
	localparam logic [127:0] textError = "STATE: ERROR    ";
	localparam logic [127:0] textWelcome = "Bienvenue A Bord";
	localparam logic [127:0] textBlank = "                ";

	lcdPkg::tableIndex_t lineOneOffset;
	lcdPkg::tableIndex_t lineTwoOffset;
	logic [127:0] lineOneText;
	logic [127:0] lineTwoText;

	// Leftmost character sits in the top byte
	function automatic lcdPkg::lcdByte_t textChar(input logic [127:0] text,
			input logic [3:0] pos);
		logic [127:0] shifted;
		shifted = text << (8 * pos);
		return shifted[127:120];
	endfunction

	assign lineOneOffset = index - lcdPkg::tableIndex_t'(lcdPkg::lineOneBase);
	assign lineTwoOffset = index - lcdPkg::tableIndex_t'(lcdPkg::lineTwoBase);

	always_comb
	begin
		case (msg)
			msgBanner:     lineOneText = textBanner;
			msgInit:       lineOneText = textInit;
			msgConfig:     lineOneText = textConfig;
			msgRunning:    lineOneText = textRunning;
			msgConnecting: lineOneText = textConnecting;
			default:       lineOneText = textError;
		endcase
	end

	// Only the banner has a second line
	assign lineTwoText = (msg == msgBanner) ? textWelcome : textBlank;

	always_comb
	begin
		word = blankChar;
		if (index < lcdPkg::tableIndex_t'(lcdPkg::lineOneBase))
		begin
			case (index[2:0])
				3'd0:    word = cmdFunctionSet;
				3'd1:    word = cmdDisplayOn;
				3'd2:    word = cmdClear;
				3'd3:    word = cmdEntryMode;
				3'd4:    word = cmdHome;
				default: word = blankChar;
			endcase
		end
		else if (index < lcdPkg::tableIndex_t'(lcdPkg::lineChangeIndex))
			word = {1'b1, textChar(lineOneText, lineOneOffset[3:0])};
		else if (index == lcdPkg::tableIndex_t'(lcdPkg::lineChangeIndex))
			word = cmdLineTwo;
		else if (index < lcdPkg::tableIndex_t'(lcdPkg::tableLength))
			word = {1'b1, textChar(lineTwoText, lineTwoOffset[3:0])};
	end

endmodule

`default_nettype wire

// ==== rtl/lcdSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdSequencer #(
	parameter int settleCycles = 100000
) (
	input  logic                iCLK,
	input  logic                iRST_N,
	input  lcdPkg::msgSel_t     msgSel,
	input  lcdPkg::romWord_t    romWord,
	input  logic                wrDone,
	output lcdPkg::tableIndex_t romIndex,
	output lcdPkg::msgSel_t     romMsg,
	output lcdPkg::lcdByte_t    wrData,
	output logic                wrRs,
	output logic                wrStart
);

	localparam int settleWidth = (settleCycles > 1) ? $clog2(settleCycles) : 1;

	typedef enum logic [1:0] {
		stIdle,
		stWriting,
		stSettling,
		stAdvance
	} seqState_t;

	seqState_t seqState;
	lcdPkg::msgSel_t latchedMsg;
	logic [settleWidth-1:0] settleCnt;
	logic msgChanged;
	logic tableDone;
	logic writeLaunch;

	assign msgChanged = (latchedMsg != romMsg);
	assign tableDone = (romIndex >= lcdPkg::tableIndex_t'(lcdPkg::tableLength));
	assign writeLaunch = (seqState == stIdle) && !msgChanged && !tableDone;

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			seqState <= stIdle;
			latchedMsg <= '0;
			romMsg <= '0;
			romIndex <= '0;
			settleCnt <= '0;
			wrStart <= 1'b0;
		end
		else
		begin
			latchedMsg <= msgSel;
			wrStart <= 1'b0;
			case (seqState)
				stIdle:
				begin
					// A new selector restarts from the init commands
					if (msgChanged)
					begin
						romMsg <= latchedMsg;
						romIndex <= '0;
					end
					else if (!tableDone)
					begin
						wrStart <= 1'b1;
						seqState <= stWriting;
					end
				end
				stWriting:
				begin
					if (wrDone)
					begin
						// The done cycle counts as the first settle cycle
						settleCnt <= settleWidth'(1);
						if (settleCycles > 1)
							seqState <= stSettling;
						else
							seqState <= stAdvance;
					end
				end
				stSettling:
				begin
					if (settleCnt == settleWidth'(settleCycles - 1))
						seqState <= stAdvance;
					else
						settleCnt <= settleCnt + 1'b1;
				end
				stAdvance:
				begin
					romIndex <= romIndex + 1'b1;
					seqState <= stIdle;
				end
				default:
					seqState <= stIdle;
			endcase
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (writeLaunch)
		begin
			wrData <= romWord[7:0];
			wrRs <= romWord[8];
		end
	end

	// Strobe belongs to the idle to writing step only
	assert property (@(posedge iCLK) disable iff (!iRST_N)
		wrStart |-> (seqState == stWriting) && ($past(seqState) == stIdle));

	// Bus controller finishes only the write that was started here
	assert property (@(posedge iCLK) disable iff (!iRST_N)
		wrDone |-> seqState == stWriting);

endmodule

`default_nettype wire

// ==== rtl/lcdBusController.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdBusController #(
	parameter int enablePulseCycles = 16
) (
	input  logic             iCLK,
	input  logic             iRST_N,
	input  lcdPkg::lcdByte_t wrData,
	input  logic             wrRs,
	input  logic             wrStart,
	output logic             wrDone,
	output lcdPkg::lcdByte_t lcdData,
	output logic             lcdRs,
	output logic             lcdEn
);

	localparam int pulseWidth = (enablePulseCycles > 1) ? $clog2(enablePulseCycles) : 1;

	typedef enum logic [1:0] {
		busIdle,
		busSetup,
		busEnable,
		busDone
	} busState_t;

	busState_t busState;
	logic [pulseWidth-1:0] pulseCnt;

	assign wrDone = (busState == busDone);

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			busState <= busIdle;
			pulseCnt <= '0;
			lcdData <= '0;
			lcdRs <= 1'b0;
			lcdEn <= 1'b0;
		end
		else
		begin
			case (busState)
				busIdle:
				begin
					if (wrStart)
					begin
						lcdData <= wrData;
						lcdRs <= wrRs;
						busState <= busSetup;
					end
				end
				busSetup:
				begin
					// Address setup cycle before enable rises
					lcdEn <= 1'b1;
					pulseCnt <= '0;
					busState <= busEnable;
				end
				busEnable:
				begin
					if (pulseCnt == pulseWidth'(enablePulseCycles - 1))
					begin
						lcdEn <= 1'b0;
						busState <= busDone;
					end
					else
						pulseCnt <= pulseCnt + 1'b1;
				end
				default:
					busState <= busIdle;
			endcase
		end
	end

	assert property (@(posedge iCLK) disable iff (!iRST_N)
		wrStart |-> busState == busIdle);

	assert property (@(posedge iCLK) disable iff (!iRST_N)
		$rose(lcdEn) |-> ##enablePulseCycles !lcdEn);

	// Data was set up a cycle earlier and holds under the pulse
	assert property (@(posedge iCLK) disable iff (!iRST_N)
		lcdEn |-> $stable(lcdData) && $stable(lcdRs));

endmodule

`default_nettype wire

// ==== rtl/lcdStatusDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdStatusDisplay #(
	parameter int enablePulseCycles = 16,
	parameter int settleCycles = 100000
) (
	input  logic             iCLK,
	input  logic             iRST_N,
	input  lcdPkg::msgSel_t  msgSel,
	output lcdPkg::lcdByte_t lcdData,
	output logic             lcdRs,
	output logic             lcdEn,
	output logic             lcdRw
);

	lcdPkg::tableIndex_t romIndex;
	lcdPkg::msgSel_t romMsg;
	lcdPkg::romWord_t romWord;
	lcdPkg::lcdByte_t wrData;
	logic wrRs;
	logic wrStart;
	logic wrDone;

	lcdSequencer #(
		.settleCycles(settleCycles)
	) lcdSequencer_i (
		.iCLK    (iCLK),
		.iRST_N  (iRST_N),
		.msgSel  (msgSel),
		.romWord (romWord),
		.wrDone  (wrDone),
		.romIndex(romIndex),
		.romMsg  (romMsg),
		.wrData  (wrData),
		.wrRs    (wrRs),
		.wrStart (wrStart)
	);

	lcdMessageRom lcdMessageRom_i (
		.msg  (romMsg),
		.index(romIndex),
		.word (romWord)
	);

	lcdBusController #(
		.enablePulseCycles(enablePulseCycles)
	) lcdBusController_i (
		.iCLK   (iCLK),
		.iRST_N (iRST_N),
		.wrData (wrData),
		.wrRs   (wrRs),
		.wrStart(wrStart),
		.wrDone (wrDone),
		.lcdData(lcdData),
		.lcdRs  (lcdRs),
		.lcdEn  (lcdEn)
	);

	// Write only, the busy flag is never read
	assign lcdRw = 1'b0;

endmodule

`default_nettype wire

// ==== dv/lcdStatusDisplayTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdStatusDisplayTb;

	localparam int enablePulseCycles = 3;
	localparam int settleCycles = 20;
	localparam int clkPeriod = 10;
	localparam int writeSpacing = enablePulseCycles + settleCycles + 4;
	// Eight tables worth of writes plus seven quiet windows of two spacings
	localparam int expectedWrites = 8 * lcdPkg::tableLength + 7 * 2;
	localparam int timeoutNs = (expectedWrites * writeSpacing + 100) * clkPeriod;

	logic iCLK;
	logic iRST_N;
	lcdPkg::msgSel_t msgSel;
	lcdPkg::lcdByte_t lcdData;
	logic lcdRs;
	logic lcdEn;
	logic lcdRw;

	integer errorCount;
	time riseTime;
	lcdPkg::lcdByte_t dataQ[$];
	logic rsQ[$];
	time riseQ[$];

	lcdStatusDisplay #(
		.enablePulseCycles(enablePulseCycles),
		.settleCycles(settleCycles)
	) lcdStatusDisplay_i (
		.iCLK   (iCLK),
		.iRST_N (iRST_N),
		.msgSel (msgSel),
		.lcdData(lcdData),
		.lcdRs  (lcdRs),
		.lcdEn  (lcdEn),
		.lcdRw  (lcdRw)
	);

	initial
		iCLK = 1'b0;

	always #(clkPeriod / 2) iCLK = ~iCLK;

	task automatic reportMismatch(input string text);
		errorCount++;
		$display("FAILED at time %0t: %s", $time, text);
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic checkByte(input lcdPkg::lcdByte_t got, input lcdPkg::lcdByte_t exp,
			input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic checkRs(input logic got, input logic exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic checkCount(input integer got, input integer exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	// Expected table word from the HD44780 command set and message texts
	function automatic lcdPkg::romWord_t expectedWord(input lcdPkg::msgSel_t msg, input int idx);
		string lineOne;
		string line;
		int pos;
		lcdPkg::romWord_t word;
		case (msg)
			3'd0:    lineOne = "Banc-d-Test SAFE";
			3'd1:    lineOne = "STATE: INIT";
			3'd2:    lineOne = "STATE: CONFIG";
			3'd3:    lineOne = "STATE: RUNNING";
			3'd7:    lineOne = "STATE: CONNECTIN";
			default: lineOne = "STATE: ERROR";
		endcase
		word = 9'h120;
		if (idx < lcdPkg::lineOneBase)
		begin
			case (idx)
				0:       word = 9'h038;
				1:       word = 9'h00C;
				2:       word = 9'h001;
				3:       word = 9'h006;
				default: word = 9'h080;
			endcase
		end
		else if (idx == lcdPkg::lineChangeIndex)
			word = 9'h0C0;
		else
		begin
			if (idx < lcdPkg::lineChangeIndex)
			begin
				line = lineOne;
				pos = idx - lcdPkg::lineOneBase;
			end
			else
			begin
				if (msg == 3'd0)
					line = "Bienvenue A Bord";
				else
					line = "";
				pos = idx - lcdPkg::lineTwoBase;
			end
			// Short texts end in blanks
			if (pos < line.len())
				word = {1'b1, line[pos]};
		end
		return word;
	endfunction

	// Bus monitor capturing one write per enable pulse
	always
	begin
		@(posedge lcdEn);
		riseTime = $time;
		@(negedge lcdEn);
		dataQ.push_back(lcdData);
		rsQ.push_back(lcdRs);
		riseQ.push_back(riseTime);
		checkCount(integer'(($time - riseTime) / clkPeriod), enablePulseCycles,
			"lcdEn pulse width in cycles");
	end

	always @(negedge iCLK)
	begin
		checkRs(lcdRw, 1'b0, "lcdRw");
	end

	task automatic clearCaptures();
		dataQ.delete();
		rsQ.delete();
		riseQ.delete();
	endtask

	task automatic waitWrites(input int count);
		while (dataQ.size() < count)
			@(negedge iCLK);
	endtask

	task automatic checkEntries(input lcdPkg::msgSel_t msg, input int firstPos,
			input int firstIdx, input int count);
		lcdPkg::romWord_t word;
		for (int i = 0; i < count; i++)
		begin
			word = expectedWord(msg, firstIdx + i);
			checkByte(dataQ[firstPos + i], word[7:0],
				$sformatf("msg %0d entry %0d lcdData", msg, firstIdx + i));
			checkRs(rsQ[firstPos + i], word[8],
				$sformatf("msg %0d entry %0d lcdRs", msg, firstIdx + i));
		end
	endtask

	// Nothing more may reach the bus once the table is done
	task automatic checkQuiet(input int expected);
		repeat (2 * writeSpacing) @(negedge iCLK);
		checkCount(dataQ.size(), expected, "write count after table end");
	endtask

	task automatic runTable(input lcdPkg::msgSel_t msg);
		@(negedge iCLK);
		clearCaptures();
		msgSel = msg;
		waitWrites(lcdPkg::tableLength);
		checkEntries(msg, 0, 0, lcdPkg::tableLength);
		checkQuiet(lcdPkg::tableLength);
	endtask

	task automatic testInitCommands();
		waitWrites(lcdPkg::lineOneBase);
		checkEntries(3'd0, 0, 0, lcdPkg::lineOneBase);
	endtask

	task automatic testBannerTable();
		waitWrites(lcdPkg::tableLength);
		checkEntries(3'd0, 0, 0, lcdPkg::tableLength);
		checkQuiet(lcdPkg::tableLength);
	endtask

	task automatic testStatusTables();
		lcdPkg::msgSel_t codes[5];
		codes = '{3'd1, 3'd2, 3'd3, 3'd7, lcdPkg::msgSel_t'($urandom_range(6, 4))};
		foreach (codes[i])
			runTable(codes[i]);
	endtask

	task automatic testMidTableChange();
		lcdPkg::msgSel_t nextMsg;
		int changeAfter;
		int startPos;
		time threshold;
		nextMsg = lcdPkg::msgSel_t'($urandom_range(7, 1));
		changeAfter = int'($urandom_range(30, 3));
		@(negedge iCLK);
		clearCaptures();
		msgSel = 3'd0;
		waitWrites(changeAfter);
		@(negedge iCLK);
		msgSel = nextMsg;
		threshold = $time + 3 * clkPeriod;
		startPos = -1;
		while (startPos < 0)
		begin
			@(negedge iCLK);
			if (riseQ.size() > 0 && riseQ[riseQ.size() - 1] >= threshold)
				startPos = riseQ.size() - 1;
		end
		// Writes begun before the restart still belong to the banner
		checkEntries(3'd0, 0, 0, startPos);
		waitWrites(startPos + lcdPkg::tableLength);
		checkEntries(nextMsg, startPos, 0, lcdPkg::tableLength);
		checkQuiet(startPos + lcdPkg::tableLength);
	endtask

	initial
	begin
		#(timeoutNs);
		$display("Timeout: the tests did not finish within %0d ns", timeoutNs);
		$display("FAIL: see errors above");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		errorCount = 0;
		iRST_N = 1'b0;
		msgSel = '0;
		void'($urandom(32'h6a64_8b34));
		repeat (4) @(negedge iCLK);
		iRST_N = 1'b1;
		testInitCommands();
		testBannerTable();
		testStatusTables();
		testMidTableChange();
		if (errorCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/lcdPkg.sv
rtl/lcdMessageRom.sv
rtl/lcdSequencer.sv
rtl/lcdBusController.sv
rtl/lcdStatusDisplay.sv
dv/lcdStatusDisplayTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lcdStatusDisplayTb
OBJ_DIR ?= obj_dir
FILE_LIST ?= sources.f
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
